// File: gpu_host_config.svh
// GPU host bridge constants
`ifndef GPU_HOST_CONFIG_SVH
`define GPU_HOST_CONFIG_SVH

// ====================
// bus widths
`define GPU_DATA_W 32 // host and gpu data words
`define GPU_OFS_W 4 // offset bits taken from the axi address
`define DBG_CNT_W 28 // debug count field inside the flags word

// ====================
// register map
`define REG_GP0 4'h0 // gpu command port gp0
`define REG_GP1 4'h4 // gpu control port gp1
`define REG_FLAGS 4'h8 // flags read, control write
`define REG_DMA 4'hC // dma data word

// control word bits, flags register write
`define CTRL_DMA_ACK_BIT 31
`define CTRL_GPU_RUN_BIT 30

// ====================
// video timing, one pixel per clock
`define H_TOTAL 768
`define V_TOTAL 512
`define H_ACTIVE 640
`define V_ACTIVE 480
`define HS_CODE 45 // hsync while h / 16 matches this
`define VS_FIRST 500
`define VS_LAST 506

`endif

// File: gpu_host_pkg.sv
// GPU host bridge types
`default_nettype none

package gpu_host_pkg;

	// one decoded bus access
	typedef enum logic [3:0] {
		OP_NONE,
		OP_GP0_WR,
		OP_GP1_WR,
		OP_CTRL_WR, // flags offset, write side
		OP_DMA_WR,
		OP_GP0_RD,
		OP_GP1_RD,
		OP_FLAGS_RD,
		OP_DMA_RD,
		OP_BAD_WR, // unmapped offsets
		OP_BAD_RD
	} bridge_op_t;

	// axi response code
	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t RESP_OKAY = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	// direction of an operation, picks the response channel
	function automatic logic is_read_op(input bridge_op_t op);
		return (op == OP_GP0_RD) || (op == OP_GP1_RD) ||
			(op == OP_FLAGS_RD) || (op == OP_DMA_RD) || (op == OP_BAD_RD);
	endfunction

	// reads that must wait for the gpu read-valid
	function automatic logic is_gpu_read(input bridge_op_t op);
		return (op == OP_GP0_RD) || (op == OP_GP1_RD);
	endfunction

endpackage

`default_nettype wire

// File: gpu_reg_decode.sv
// AXI4-Lite request decode
`timescale 1ns/10ps
`default_nettype none

`include "gpu_host_config.svh"

module gpu_reg_decode (
	input wire logic clk_sys,
	input wire logic reset,
	// write address and data channels
	input wire logic i_awvalid,
	input wire logic [`GPU_OFS_W-1:0] i_awaddr,
	output logic o_awready,
	input wire logic i_wvalid,
	input wire logic [`GPU_DATA_W-1:0] i_wdata,
	output logic o_wready,
	// read address channel
	input wire logic i_arvalid,
	input wire logic [`GPU_OFS_W-1:0] i_araddr,
	output logic o_arready,
	// toward the sequencer
	input wire logic i_idle,
	output logic o_start,
	output gpu_host_pkg::bridge_op_t o_op,
	output logic [`GPU_DATA_W-1:0] o_wdata
);
	import gpu_host_pkg::*;

	logic accept_wr;
	logic accept_rd;
	bridge_op_t wr_op;
	bridge_op_t rd_op;

	// ====================
	// acceptance
	// a start in flight counts as busy until the sequencer sees it
	assign accept_wr = i_awvalid & i_wvalid & i_idle & ~o_start;
	// any write channel activity blocks reads so writes win
	assign accept_rd = i_arvalid & ~i_awvalid & ~i_wvalid & i_idle & ~o_start;

	assign o_awready = accept_wr; // aw and w taken together
	assign o_wready = accept_wr;
	assign o_arready = accept_rd;

	// ====================
	// offset map
	always_comb begin
		case (i_awaddr)
			`REG_GP0: wr_op = OP_GP0_WR;
			`REG_GP1: wr_op = OP_GP1_WR;
			`REG_FLAGS: wr_op = OP_CTRL_WR; // run level and dma ack
			`REG_DMA: wr_op = OP_DMA_WR;
			default: wr_op = OP_BAD_WR; // answered with slverr
		endcase
	end

	always_comb begin
		case (i_araddr)
			`REG_GP0: rd_op = OP_GP0_RD;
			`REG_GP1: rd_op = OP_GP1_RD;
			`REG_FLAGS: rd_op = OP_FLAGS_RD;
			`REG_DMA: rd_op = OP_DMA_RD;
			default: rd_op = OP_BAD_RD;
		endcase
	end

	// op is held until the next accepted request
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			o_start <= 1'b0;
			o_op <= OP_NONE;
		end else begin
			o_start <= accept_wr | accept_rd; // one clock pulse
			if (accept_wr)
				o_op <= wr_op;
			else if (accept_rd)
				o_op <= rd_op;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept_wr)
			o_wdata <= i_wdata;
	end

	// one channel handshakes at a time
	a_ready_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(o_awready && o_arready));

endmodule

`default_nettype wire

// File: gpu_port_sequencer.sv
// GPU port sequencer
`timescale 1ns/10ps
`default_nettype none

`include "gpu_host_config.svh"

module gpu_port_sequencer (
	input wire logic clk_sys,
	input wire logic reset,
	// from decode
	input wire logic i_start,
	input wire gpu_host_pkg::bridge_op_t i_op,
	input wire logic [`GPU_DATA_W-1:0] i_wdata,
	// gpu side
	input wire logic [`GPU_DATA_W-1:0] i_gpu_rdata,
	input wire logic i_gpu_rvalid,
	input wire logic i_gpu_irq,
	input wire logic i_gpu_dma_req,
	input wire logic i_gpu_can_write,
	input wire logic [`DBG_CNT_W-1:0] i_gpu_dbg_cnt,
	output logic o_gpu_sel,
	output logic o_gpu_write,
	output logic o_gpu_read,
	output logic o_gpu_a2,
	output logic [`GPU_DATA_W-1:0] o_gpu_wdata,
	output logic o_gpu_nrst,
	output logic o_dma_ack,
	// toward the response channels
	input wire logic i_resp_busy,
	output logic o_done,
	output logic o_is_read,
	output logic [`GPU_DATA_W-1:0] o_rdata,
	output gpu_host_pkg::axi_resp_t o_resp,
	output logic o_idle
);
	import gpu_host_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_GPU, // read strobe sent, waiting on rvalid
		ST_DONE // result lands in the response channel
	} seq_state_t;

	seq_state_t state;
	logic run_q;
	logic [`GPU_DATA_W-1:0] flag_word;

	// status word, msb always zero
	assign flag_word = {1'b0, i_gpu_dma_req, i_gpu_irq, i_gpu_can_write, i_gpu_dbg_cnt};

	assign o_gpu_a2 = (i_op == OP_GP1_WR) || (i_op == OP_GP1_RD); // gp1 select
	assign o_gpu_wdata = i_wdata; // held by decode for the whole access
	assign o_gpu_nrst = run_q & ~reset;
	assign o_is_read = is_read_op(i_op);
	assign o_idle = (state == ST_IDLE) & ~i_resp_busy;

	// ====================
	// strobes and completion, all in the start clock except gpu reads
	always_comb begin
		o_gpu_sel = 1'b0;
		o_gpu_write = 1'b0;
		o_gpu_read = 1'b0;
		o_dma_ack = 1'b0;
		o_done = 1'b0;
		o_rdata = '0;
		o_resp = RESP_OKAY;
		case (state)
			ST_IDLE: begin
				if (i_start) begin
					case (i_op)
						OP_GP0_WR, OP_GP1_WR: begin
							o_gpu_sel = 1'b1;
							o_gpu_write = 1'b1;
							o_done = 1'b1;
						end
						OP_DMA_WR: begin
							o_gpu_write = 1'b1; // no sel for dma data
							o_dma_ack = 1'b1;
							o_done = 1'b1;
						end
						OP_CTRL_WR: begin
							o_dma_ack = i_wdata[`CTRL_DMA_ACK_BIT];
							o_done = 1'b1;
						end
						OP_GP0_RD, OP_GP1_RD: begin
							o_gpu_sel = 1'b1;
							o_gpu_read = 1'b1; // done follows rvalid
						end
						OP_FLAGS_RD: begin
							o_rdata = flag_word;
							o_done = 1'b1;
						end
						OP_DMA_RD: begin
							o_rdata = i_gpu_rdata; // no strobe
							o_done = 1'b1;
						end
						default: begin
							o_resp = RESP_SLVERR; // unmapped, gpu untouched
							o_done = 1'b1;
						end
					endcase
				end
			end
			ST_WAIT_GPU: begin
				if (i_gpu_rvalid) begin
					o_rdata = i_gpu_rdata;
					o_done = 1'b1;
				end
			end
			default: ;
		endcase
	end

	// ====================
	// state and run level
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state <= ST_IDLE;
			run_q <= 1'b1; // gpu runs from reset release
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_start) begin
						state <= is_gpu_read(i_op) ? ST_WAIT_GPU : ST_DONE;
						if (i_op == OP_CTRL_WR)
							run_q <= i_wdata[`CTRL_GPU_RUN_BIT];
					end
				end
				ST_WAIT_GPU: if (i_gpu_rvalid) state <= ST_DONE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// gpu sees single clock strobes only
	a_strobe_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		(o_gpu_write || o_gpu_read) |=> !(o_gpu_write || o_gpu_read));

	// decode only starts into an idle bridge
	a_start_idle: assert property (@(posedge clk_sys) disable iff (reset)
		i_start |-> o_idle);

endmodule

`default_nettype wire

// File: gpu_bus_response.sv
// AXI4-Lite response channels
`timescale 1ns/10ps
`default_nettype none

`include "gpu_host_config.svh"

module gpu_bus_response (
	input wire logic clk_sys,
	input wire logic reset,
	// completed result from the sequencer
	input wire logic i_done,
	input wire logic i_is_read,
	input wire logic [`GPU_DATA_W-1:0] i_rdata,
	input wire gpu_host_pkg::axi_resp_t i_resp,
	// write response channel
	output logic o_bvalid,
	output gpu_host_pkg::axi_resp_t o_bresp,
	input wire logic i_bready,
	// read data channel
	output logic o_rvalid,
	output logic [`GPU_DATA_W-1:0] o_rdata,
	output gpu_host_pkg::axi_resp_t o_rresp,
	input wire logic i_rready,
	output logic o_busy
);

	assign o_busy = o_bvalid | o_rvalid; // holds the bridge off

	// valid flags, cleared on the host handshake
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			o_bvalid <= 1'b0;
			o_rvalid <= 1'b0;
		end else begin
			if (o_bvalid && i_bready)
				o_bvalid <= 1'b0;
			else if (i_done && !i_is_read)
				o_bvalid <= 1'b1;

			if (o_rvalid && i_rready)
				o_rvalid <= 1'b0;
			else if (i_done && i_is_read)
				o_rvalid <= 1'b1;
		end
	end

	// payload only loads on done
	always_ff @(posedge clk_sys) begin
		if (i_done && !i_is_read)
			o_bresp <= i_resp;
		if (i_done && i_is_read) begin
			o_rdata <= i_rdata;
			o_rresp <= i_resp;
		end
	end

	// held under back-pressure, no new result can overwrite it
	a_b_hold: assert property (@(posedge clk_sys) disable iff (reset)
		(o_bvalid && !i_bready) |=> o_bvalid && $stable(o_bresp));

	a_r_hold: assert property (@(posedge clk_sys) disable iff (reset)
		(o_rvalid && !i_rready) |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp));

endmodule

`default_nettype wire

// File: video_test_pattern.sv
// 640x480 XOR test pattern
`timescale 1ns/10ps
`default_nettype none

`include "gpu_host_config.svh"

module video_test_pattern (
	input wire logic clk_sys,
	input wire logic reset,
	output logic o_hs,
	output logic o_vs,
	output logic o_de,
	output logic [7:0] o_r,
	output logic [7:0] o_g,
	output logic [7:0] o_b
);
	localparam int H_W = $clog2(`H_TOTAL); // 10 bits
	localparam int V_W = $clog2(`V_TOTAL); // 9 bits

	logic [H_W-1:0] hcnt;
	logic [V_W-1:0] vcnt;

	// ====================
	// raster counters, one pixel per clock
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (hcnt == H_W'(`H_TOTAL - 1)) begin
			hcnt <= '0;
			// frame wrap
			if (vcnt == V_W'(`V_TOTAL - 1))
				vcnt <= '0;
			else
				vcnt <= vcnt + 1'b1;
		end else begin
			hcnt <= hcnt + 1'b1;
		end
	end

	// sync and blanking
	assign o_hs = (hcnt[H_W-1:4] == (H_W-4)'(`HS_CODE)); // 16 clock wide pulse
	assign o_vs = (vcnt >= V_W'(`VS_FIRST)) && (vcnt <= V_W'(`VS_LAST));
	assign o_de = (hcnt < H_W'(`H_ACTIVE)) && (vcnt < V_W'(`V_ACTIVE));

	// ====================
	// colour, driven in blanking as well
	assign o_r = hcnt[7:0] ^ vcnt[8:1];
	assign o_g = hcnt[8:1] ^ vcnt[7:0];
	assign o_b = hcnt[9:2] ^ vcnt[8:1];

endmodule

`default_nettype wire

// File: gpu_host_top.sv
// GPU host bridge top
`timescale 1ns/10ps
`default_nettype none

`include "gpu_host_config.svh"

module gpu_host_top (
	input wire logic clk_sys,
	input wire logic reset,
	// axi4-lite slave
	input wire logic i_s_axi_awvalid,
	output logic o_s_axi_awready,
	input wire logic [`GPU_OFS_W-1:0] i_s_axi_awaddr,
	input wire logic i_s_axi_wvalid,
	output logic o_s_axi_wready,
	input wire logic [`GPU_DATA_W-1:0] i_s_axi_wdata,
	output logic o_s_axi_bvalid,
	input wire logic i_s_axi_bready,
	output gpu_host_pkg::axi_resp_t o_s_axi_bresp,
	input wire logic i_s_axi_arvalid,
	output logic o_s_axi_arready,
	input wire logic [`GPU_OFS_W-1:0] i_s_axi_araddr,
	output logic o_s_axi_rvalid,
	input wire logic i_s_axi_rready,
	output logic [`GPU_DATA_W-1:0] o_s_axi_rdata,
	output gpu_host_pkg::axi_resp_t o_s_axi_rresp,
	// gpu ports
	output logic o_gpu_sel,
	output logic o_gpu_write,
	output logic o_gpu_read,
	output logic o_gpu_a2,
	output logic [`GPU_DATA_W-1:0] o_gpu_wdata,
	output logic o_gpu_nrst,
	output logic o_dma_ack,
	input wire logic [`GPU_DATA_W-1:0] i_gpu_rdata,
	input wire logic i_gpu_rvalid,
	input wire logic i_gpu_irq,
	input wire logic i_gpu_dma_req,
	input wire logic i_gpu_can_write,
	input wire logic [`DBG_CNT_W-1:0] i_gpu_dbg_cnt,
	// test pattern video
	output logic o_vga_hs,
	output logic o_vga_vs,
	output logic o_vga_de,
	output logic [7:0] o_vga_r,
	output logic [7:0] o_vga_g,
	output logic [7:0] o_vga_b
);
	import gpu_host_pkg::*;

	logic start;
	bridge_op_t op;
	logic [`GPU_DATA_W-1:0] wdata;
	logic idle;
	logic done;
	logic is_read;
	logic [`GPU_DATA_W-1:0] seq_rdata;
	axi_resp_t seq_resp;
	logic resp_busy;

	// ====================
	// register bridge
	gpu_reg_decode u_decode (
		.clk_sys(clk_sys), .reset(reset),
		.i_awvalid(i_s_axi_awvalid), .i_awaddr(i_s_axi_awaddr), .o_awready(o_s_axi_awready),
		.i_wvalid(i_s_axi_wvalid), .i_wdata(i_s_axi_wdata), .o_wready(o_s_axi_wready),
		.i_arvalid(i_s_axi_arvalid), .i_araddr(i_s_axi_araddr), .o_arready(o_s_axi_arready),
		.i_idle(idle), .o_start(start), .o_op(op), .o_wdata(wdata)
	);

	gpu_port_sequencer u_seq (
		.clk_sys(clk_sys), .reset(reset),
		.i_start(start), .i_op(op), .i_wdata(wdata),
		.i_gpu_rdata(i_gpu_rdata), .i_gpu_rvalid(i_gpu_rvalid),
		.i_gpu_irq(i_gpu_irq), .i_gpu_dma_req(i_gpu_dma_req),
		.i_gpu_can_write(i_gpu_can_write), .i_gpu_dbg_cnt(i_gpu_dbg_cnt),
		.o_gpu_sel(o_gpu_sel), .o_gpu_write(o_gpu_write), .o_gpu_read(o_gpu_read),
		.o_gpu_a2(o_gpu_a2), .o_gpu_wdata(o_gpu_wdata), .o_gpu_nrst(o_gpu_nrst),
		.o_dma_ack(o_dma_ack), .i_resp_busy(resp_busy), .o_done(done),
		.o_is_read(is_read), .o_rdata(seq_rdata), .o_resp(seq_resp), .o_idle(idle)
	);

	gpu_bus_response u_resp (
		.clk_sys(clk_sys), .reset(reset),
		.i_done(done), .i_is_read(is_read), .i_rdata(seq_rdata), .i_resp(seq_resp),
		.o_bvalid(o_s_axi_bvalid), .o_bresp(o_s_axi_bresp), .i_bready(i_s_axi_bready),
		.o_rvalid(o_s_axi_rvalid), .o_rdata(o_s_axi_rdata), .o_rresp(o_s_axi_rresp),
		.i_rready(i_s_axi_rready), .o_busy(resp_busy)
	);

	// free running, independent of the bridge
	video_test_pattern u_video (
		.clk_sys(clk_sys), .reset(reset),
		.o_hs(o_vga_hs), .o_vs(o_vga_vs), .o_de(o_vga_de),
		.o_r(o_vga_r), .o_g(o_vga_g), .o_b(o_vga_b)
	);

endmodule

`default_nettype wire

// File: gpu_host_tb.sv
// GPU host bridge testbench
`timescale 1ns/10ps
`default_nettype none

`include "gpu_host_config.svh"

module gpu_host_tb;
	import gpu_host_pkg::*;

	localparam int WAIT_MAX = 200; // clocks allowed per handshake
	localparam int FRAME_CLKS = `H_TOTAL * `V_TOTAL;

	logic clk_sys;
	logic reset;
	logic i_s_axi_awvalid;
	logic [`GPU_OFS_W-1:0] i_s_axi_awaddr;
	logic i_s_axi_wvalid;
	logic [`GPU_DATA_W-1:0] i_s_axi_wdata;
	logic i_s_axi_bready;
	logic i_s_axi_arvalid;
	logic [`GPU_OFS_W-1:0] i_s_axi_araddr;
	logic i_s_axi_rready;
	logic o_s_axi_awready;
	logic o_s_axi_wready;
	logic o_s_axi_bvalid;
	logic [1:0] o_s_axi_bresp;
	logic o_s_axi_arready;
	logic o_s_axi_rvalid;
	logic [`GPU_DATA_W-1:0] o_s_axi_rdata;
	logic [1:0] o_s_axi_rresp;
	logic o_gpu_sel;
	logic o_gpu_write;
	logic o_gpu_read;
	logic o_gpu_a2;
	logic [`GPU_DATA_W-1:0] o_gpu_wdata;
	logic o_gpu_nrst;
	logic o_dma_ack;
	logic [`GPU_DATA_W-1:0] i_gpu_rdata;
	logic i_gpu_rvalid;
	logic i_gpu_irq;
	logic i_gpu_dma_req;
	logic i_gpu_can_write;
	logic [`DBG_CNT_W-1:0] i_gpu_dbg_cnt;
	logic o_vga_hs;
	logic o_vga_vs;
	logic o_vga_de;
	logic [7:0] o_vga_r;
	logic [7:0] o_vga_g;
	logic [7:0] o_vga_b;

	reg [8*24-1:0] tname; // current test name from the stimulus file
	int test_errs;
	int tests_run = 0;
	int tests_failed = 0;
	int n_wr = 0; // strobe counters written by the monitor only
	int n_rd = 0;
	int n_sel = 0;
	int n_ack = 0;
	logic last_a2;
	logic [`GPU_DATA_W-1:0] last_wdata;
	int cur_lat = 1; // gpu read latency in clocks
	int video_errs;
	logic video_done;

	gpu_host_top uut (
		.clk_sys(clk_sys), .reset(reset),
		.i_s_axi_awvalid(i_s_axi_awvalid), .o_s_axi_awready(o_s_axi_awready),
		.i_s_axi_awaddr(i_s_axi_awaddr), .i_s_axi_wvalid(i_s_axi_wvalid),
		.o_s_axi_wready(o_s_axi_wready), .i_s_axi_wdata(i_s_axi_wdata),
		.o_s_axi_bvalid(o_s_axi_bvalid), .i_s_axi_bready(i_s_axi_bready),
		.o_s_axi_bresp(o_s_axi_bresp), .i_s_axi_arvalid(i_s_axi_arvalid),
		.o_s_axi_arready(o_s_axi_arready), .i_s_axi_araddr(i_s_axi_araddr),
		.o_s_axi_rvalid(o_s_axi_rvalid), .i_s_axi_rready(i_s_axi_rready),
		.o_s_axi_rdata(o_s_axi_rdata), .o_s_axi_rresp(o_s_axi_rresp),
		.o_gpu_sel(o_gpu_sel), .o_gpu_write(o_gpu_write), .o_gpu_read(o_gpu_read),
		.o_gpu_a2(o_gpu_a2), .o_gpu_wdata(o_gpu_wdata), .o_gpu_nrst(o_gpu_nrst),
		.o_dma_ack(o_dma_ack), .i_gpu_rdata(i_gpu_rdata), .i_gpu_rvalid(i_gpu_rvalid),
		.i_gpu_irq(i_gpu_irq), .i_gpu_dma_req(i_gpu_dma_req),
		.i_gpu_can_write(i_gpu_can_write), .i_gpu_dbg_cnt(i_gpu_dbg_cnt),
		.o_vga_hs(o_vga_hs), .o_vga_vs(o_vga_vs), .o_vga_de(o_vga_de),
		.o_vga_r(o_vga_r), .o_vga_g(o_vga_g), .o_vga_b(o_vga_b)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys; // 4 ns period
	end

	// ====================
	// strobe monitor for the gpu model
	always @(negedge clk_sys) begin
		if (o_gpu_write) begin
			n_wr++;
			last_wdata = o_gpu_wdata;
		end
		if (o_gpu_read)
			n_rd++;
		if (o_gpu_sel) begin
			n_sel++;
			last_a2 = o_gpu_a2; // port select seen with the strobe
		end
		if (o_dma_ack)
			n_ack++;
	end

	// read-valid follows cur_lat clocks later with data already on i_gpu_rdata
	initial begin
		forever begin
			@(negedge clk_sys);
			if (o_gpu_read) begin
				repeat (cur_lat) @(negedge clk_sys);
				i_gpu_rvalid = 1'b1;
				@(negedge clk_sys);
				i_gpu_rvalid = 1'b0;
			end
		end
	end

	// ====================
	// host driver
	task automatic report_value(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		$display("[ERROR] %0s %0s expected %h actual %h", tname, what, exp, act);
		test_errs++;
	endtask

	task automatic abort_run(input string why);
		$display("%0s: %0s, run stopped", tname, why);
		$display("Something failed");
		$finish;
	endtask

	task automatic send_request(input logic rd, input logic [3:0] ofs, input logic [31:0] wd);
		int n;
		n = 0;
		@(negedge clk_sys);
		if (rd) begin
			i_s_axi_arvalid = 1'b1;
			i_s_axi_araddr = ofs;
		end else begin
			i_s_axi_awvalid = 1'b1; // aw and w offered together
			i_s_axi_awaddr = ofs;
			i_s_axi_wvalid = 1'b1;
			i_s_axi_wdata = wd;
		end
		#1;
		while (!(rd ? o_s_axi_arready : (o_s_axi_awready && o_s_axi_wready))) begin
			n++;
			if (n > WAIT_MAX)
				abort_run("request never accepted by the bridge");
			@(negedge clk_sys);
			#1;
		end
		@(negedge clk_sys); // handshake took place on the rising edge
		i_s_axi_arvalid = 1'b0;
		i_s_axi_awvalid = 1'b0;
		i_s_axi_wvalid = 1'b0;
	endtask

	// flags read offered while a response is held waits its turn
	task automatic drain_probe(input logic [31:0] exp_flags);
		int n;
		n = 0;
		#1;
		while (!o_s_axi_arready) begin
			n++;
			if (n > WAIT_MAX)
				abort_run("queued request not taken after the response drained");
			@(negedge clk_sys);
			#1;
		end
		@(negedge clk_sys);
		i_s_axi_arvalid = 1'b0;
		i_s_axi_rready = 1'b1;
		n = 0;
		#1;
		while (!o_s_axi_rvalid) begin
			n++;
			if (n > WAIT_MAX)
				abort_run("queued flags read never answered");
			@(negedge clk_sys);
			#1;
		end
		if (o_s_axi_rdata !== exp_flags)
			report_value("queued flags read", exp_flags, o_s_axi_rdata);
		if (o_s_axi_rresp !== RESP_OKAY)
			report_value("queued flags resp", RESP_OKAY, o_s_axi_rresp);
		@(negedge clk_sys);
		i_s_axi_rready = 1'b0;
	endtask

	task automatic take_response(input logic rd, input int hold, input logic [31:0] exp_flags,
			output logic [31:0] data, output logic [1:0] resp);
		int n;
		int i;
		n = 0;
		@(negedge clk_sys);
		#1;
		while (!(rd ? o_s_axi_rvalid : o_s_axi_bvalid)) begin
			n++;
			if (n > WAIT_MAX)
				abort_run("no response from the bridge");
			@(negedge clk_sys);
			#1;
		end
		data = o_s_axi_rdata;
		resp = rd ? o_s_axi_rresp : o_s_axi_bresp;
		// back-pressure span
		for (i = 0; i < hold; i++) begin
			@(negedge clk_sys);
			if (i == 0) begin
				i_s_axi_arvalid = 1'b1;
				i_s_axi_araddr = `REG_FLAGS;
			end
			#1;
			if (!(rd ? o_s_axi_rvalid : o_s_axi_bvalid))
				report_value("valid under back-pressure", 1, 0);
			if ((rd ? o_s_axi_rresp : o_s_axi_bresp) !== resp)
				report_value("held resp", resp, rd ? o_s_axi_rresp : o_s_axi_bresp);
			if (rd && o_s_axi_rdata !== data)
				report_value("held rdata", data, o_s_axi_rdata);
			if (o_s_axi_arready) begin
				$display("[ERROR] %0s second request accepted before the response drained",
					tname);
				test_errs++;
			end
		end
		@(negedge clk_sys);
		i_s_axi_bready = !rd;
		i_s_axi_rready = rd;
		@(negedge clk_sys);
		i_s_axi_bready = 1'b0;
		i_s_axi_rready = 1'b0;
		if (hold > 0)
			drain_probe(exp_flags);
	endtask

	task automatic run_test(input logic rd, input logic [3:0] ofs, input logic [31:0] wd,
			input int lat, input logic [31:0] grd, input logic [2:0] flg,
			input logic [27:0] dbg, input logic [7:0] strb, input logic [31:0] exp_d,
			input logic [1:0] exp_r);
		int wr0;
		int rd0;
		int sel0;
		int ack0;
		logic [31:0] got_d;
		logic [1:0] got_r;
		logic [31:0] flag_exp;
		test_errs = 0;
		// zero bit, then dma_req irq can_write as in the file, then the debug count
		flag_exp = {1'b0, flg, dbg};
		@(negedge clk_sys);
		i_gpu_dma_req = flg[2];
		i_gpu_irq = flg[1];
		i_gpu_can_write = flg[0];
		i_gpu_dbg_cnt = dbg;
		i_gpu_rdata = grd; // dma reads take it at once
		cur_lat = lat;
		#1;
		wr0 = n_wr;
		rd0 = n_rd;
		sel0 = n_sel;
		ack0 = n_ack;
		send_request(rd, ofs, wd);
		take_response(rd, $urandom % 5, flag_exp, got_d, got_r);
		#1;
		if (n_wr - wr0 != strb[0])
			report_value("write strobes", strb[0], n_wr - wr0);
		if (n_rd - rd0 != strb[1])
			report_value("read strobes", strb[1], n_rd - rd0);
		if (n_sel - sel0 != strb[2])
			report_value("sel strobes", strb[2], n_sel - sel0);
		if (strb[2] && last_a2 !== strb[3])
			report_value("a2", strb[3], last_a2);
		if (n_ack - ack0 != strb[4])
			report_value("dma ack pulses", strb[4], n_ack - ack0);
		if (o_gpu_nrst !== strb[5])
			report_value("gpu run level", strb[5], o_gpu_nrst);
		if (strb[0] && last_wdata !== wd)
			report_value("gpu write data", wd, last_wdata);
		if (got_r !== exp_r)
			report_value("response", exp_r, got_r);
		if (rd && exp_r == RESP_OKAY && got_d !== exp_d)
			report_value("rdata", exp_d, got_d);
		tests_run++;
		if (test_errs != 0)
			tests_failed++;
		$display("%0s %0s", (test_errs == 0) ? "pass" : "FAIL", tname);
	endtask

	// ====================
	// video checker over one frame from reset release
	initial begin : video_check
		int n;
		int h;
		int v;
		logic [9:0] hv;
		logic [8:0] vv;
		logic de_x;
		logic [31:0] exp_w;
		logic [31:0] act_w;
		video_errs = 0;
		video_done = 1'b0;
		@(negedge reset);
		for (n = 0; n < FRAME_CLKS; n++) begin
			h = n % `H_TOTAL;
			v = n / `H_TOTAL;
			hv = h[9:0];
			vv = v[8:0];
			de_x = (h < `H_ACTIVE) && (v < `V_ACTIVE);
			exp_w = {5'd0, (h / 16 == `HS_CODE), (v >= `VS_FIRST && v <= `VS_LAST), de_x, 24'd0};
			act_w = {5'd0, o_vga_hs, o_vga_vs, o_vga_de, 24'd0};
			if (de_x) begin // colours only on active pixels
				exp_w[23:0] = {hv[7:0] ^ vv[8:1], hv[8:1] ^ vv[7:0], hv[9:2] ^ vv[8:1]};
				act_w[23:0] = {o_vga_r, o_vga_g, o_vga_b};
			end
			if (act_w !== exp_w) begin
				if (video_errs < 8)
					$display("[ERROR] video_frame h=%0d v=%0d expected %h actual %h",
						h, v, exp_w, act_w);
				video_errs++;
			end
			@(negedge clk_sys);
		end
		video_done = 1'b1;
	end

	// ====================
	// main sequence
	initial begin : main_seq
		int fd;
		int n;
		reg [8*200-1:0] line;
		reg [8*2-1:0] dir;
		logic [3:0] ofs;
		logic [31:0] wd;
		int lat;
		logic [31:0] grd;
		logic [2:0] flg;
		logic [27:0] dbg;
		logic [7:0] strb;
		logic [31:0] exp_d;
		logic [1:0] exp_r;
		void'($urandom(32'h46b7_5430));
		tname = "setup";
		reset = 1'b1;
		i_s_axi_awvalid = 1'b0;
		i_s_axi_awaddr = '0;
		i_s_axi_wvalid = 1'b0;
		i_s_axi_wdata = '0;
		i_s_axi_bready = 1'b0;
		i_s_axi_arvalid = 1'b0;
		i_s_axi_araddr = '0;
		i_s_axi_rready = 1'b0;
		i_gpu_rdata = '0;
		i_gpu_rvalid = 1'b0;
		i_gpu_irq = 1'b0;
		i_gpu_dma_req = 1'b0;
		i_gpu_can_write = 1'b0;
		i_gpu_dbg_cnt = '0;
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		fd = $fopen("gpu_host_stimulus.txt", "r");
		if (fd == 0)
			abort_run("cannot open gpu_host_stimulus.txt");
		while (!$feof(fd)) begin
			line = '0;
			n = $fgets(line, fd);
			n = $sscanf(line, "%s %s %h %h %d %h %h %h %h %h %h", tname, dir, ofs, wd, lat,
				grd, flg, dbg, strb, exp_d, exp_r);
			if (n <= 0 || tname == "#") begin
				// comment or blank line
			end else if (n != 11) begin
				abort_run("malformed stimulus line");
			end else begin
				run_test(dir == "rd", ofs, wd, lat, grd, flg, dbg, strb, exp_d, exp_r);
			end
		end
		$fclose(fd);
		tname = "video_frame";
		n = 0;
		while (!video_done) begin
			n++;
			if (n > FRAME_CLKS + 1000)
				abort_run("video checker never finished a frame");
			@(negedge clk_sys);
		end
		tests_run++;
		if (video_errs != 0)
			tests_failed++;
		$display("%0s video_frame (%0d mismatches)", (video_errs == 0) ? "pass" : "FAIL",
			video_errs);
		$display("tests run %0d, passed %0d, failed %0d", tests_run, tests_run - tests_failed,
			tests_failed);
		if (tests_failed == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: gpu_host_stimulus.txt
# name dir ofs wdata lat gpu_rdata flags dbg strb exp_data exp_resp
# flags bit2 dma_req bit1 irq bit0 can_write, strb bit0 wr bit1 rd bit2 sel bit3 a2 bit4 ack bit5 nrst
gp0_wr        wr 0 12345678 0 00000000 0 0000000 25 00000000 0
gp1_wr        wr 4 08000000 0 00000000 0 0000000 2d 00000000 0
gp0_wr_b      wr 0 deadbeef 0 00000000 0 0000000 25 00000000 0
gp1_wr_b      wr 4 10000001 0 00000000 0 0000000 2d 00000000 0
gp0_rd        rd 0 00000000 1 cafe0001 0 0000000 26 cafe0001 0
gp1_rd        rd 4 00000000 3 1f00beef 0 0000000 2e 1f00beef 0
gp0_rd_slow   rd 0 00000000 7 00c0ffee 0 0000000 26 00c0ffee 0
gp1_rd_fast   rd 4 00000000 1 5a5a5a5a 0 0000000 2e 5a5a5a5a 0
gp0_rd_mid    rd 0 00000000 4 13572468 0 0000000 26 13572468 0
ctrl_ack_run  wr 8 c0000000 0 00000000 0 0000000 30 00000000 0
ctrl_halt     wr 8 00000000 0 00000000 0 0000000 00 00000000 0
flags_halted  rd 8 00000000 0 00000000 5 0123456 00 50123456 0
ctrl_run      wr 8 40000000 0 00000000 0 0000000 20 00000000 0
ctrl_ack_halt wr 8 80000000 0 00000000 0 0000000 10 00000000 0
ctrl_run_b    wr 8 40000000 0 00000000 0 0000000 20 00000000 0
flags_all     rd 8 00000000 0 00000000 7 fffffff 20 7fffffff 0
flags_irq     rd 8 00000000 0 00000000 2 0000abc 20 20000abc 0
flags_none    rd 8 00000000 0 00000000 0 0000000 20 00000000 0
flags_dma     rd 8 00000000 0 00000000 4 1234567 20 41234567 0
dma_wr        wr c 01020304 0 00000000 0 0000000 31 00000000 0
dma_wr_b      wr c a5a5a5a5 0 00000000 0 0000000 31 00000000 0
dma_rd        rd c 00000000 0 89abcdef 0 0000000 20 89abcdef 0
bad_wr_2      wr 2 11111111 0 00000000 0 0000000 20 00000000 2
bad_rd_6      rd 6 00000000 0 00000000 0 0000000 20 00000000 2
bad_wr_f      wr f 22222222 0 00000000 0 0000000 20 00000000 2
bad_rd_9      rd 9 00000000 0 00000000 0 0000000 20 00000000 2

// File: gpu_host_top.f
+incdir+.
gpu_host_pkg.sv
gpu_reg_decode.sv
gpu_port_sequencer.sv
gpu_bus_response.sv
video_test_pattern.sv
gpu_host_top.sv
gpu_host_tb.sv
